//--- compile.f
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_array.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tests/tb_clk_gen.sv
tests/cache_tb.sv

//--- hw/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               enable,
   input  cache_pkg::req_op_e rw,
   input  logic               hit,
   input  logic               evict,
   input  logic               bus_r,
   output logic               ready,
   output logic               bus_en,
   output logic               bus_wr,
   output logic               use_victim_tag,
   output logic               fill,
   output logic               set_dirty,
   output logic               cpu_write,
   output logic               fill_write
);
   import cache_pkg::*;

   cache_state_e state;
   cache_state_e state_d;

   // bus pins are registered, these are their next values
   logic bus_en_d;
   logic bus_wr_d;

   logic is_write;
   logic refill_end;

   assign is_write = (rw == op_write);

   // memory answer counts only while the request is on the bus
   assign refill_end = (state == st_refill) && bus_en && bus_r;

   // next state and next bus pins
   always_comb
   begin
      state_d  = state;
      bus_en_d = bus_en;
      bus_wr_d = bus_wr;
      case (state)
         st_idle:
         begin
            if (enable)
            begin
               state_d = st_lookup;
            end
         end
         st_lookup:
         begin
            if (hit)
            begin
               state_d = st_done;
            end
            else if (evict)
            begin
               // dirty victim goes out first
               state_d  = st_evict;
               bus_en_d = 1'b1;
               bus_wr_d = 1'b1;
            end
            else
            begin
               state_d  = st_refill;
               bus_en_d = 1'b1;
               bus_wr_d = 1'b0;
            end
         end
         st_evict:
         begin
            // write-back done, bus_en stays low for one cycle
            if (bus_r)
            begin
               state_d  = st_refill;
               bus_en_d = 1'b0;
               bus_wr_d = 1'b0;
            end
         end
         st_refill:
         begin
            if (!bus_en)
            begin
               // gap after write-back is over, start the read
               bus_en_d = 1'b1;
            end
            else if (bus_r)
            begin
               // line is in, look again and hit
               state_d  = st_lookup;
               bus_en_d = 1'b0;
            end
         end
         st_done:
         begin
            state_d = st_idle;
         end
         default:
         begin
            state_d  = st_idle;
            bus_en_d = 1'b0;
            bus_wr_d = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state  <= st_idle;
         bus_en <= 1'b0;
         bus_wr <= 1'b0;
      end
      else
      begin
         state  <= state_d;
         bus_en <= bus_en_d;
         bus_wr <= bus_wr_d;
      end
   end

   // one cycle ready, write lands at the end of it
   assign ready     = (state == st_done);
   assign cpu_write = ready && is_write;
   assign set_dirty = ready && is_write;

   // refill strobes share the memory answer cycle
   assign fill       = refill_end;
   assign fill_write = refill_end;

   // write-back goes to the address of the line being thrown out
   assign use_victim_tag = (state == st_evict);

endmodule

//--- hw/cache_data_array.sv
`timescale 1ns/10ps

module cache_data_array
(
   input  logic               clk,
   input  cache_pkg::index_t  index,
   input  cache_pkg::offset_t offset,
   input  cache_pkg::size_t   size,
   input  cache_pkg::line_t   data_write,
   input  cache_pkg::line_t   fill_line,
   input  logic               cpu_write,
   input  logic               fill_write,
   output cache_pkg::line_t   line_out,
   output cache_pkg::line_t   data_read
);
   import cache_pkg::*;

   // line storage
   line_t mem [NUM_LINES];

   // byte enables before and after the offset shift
   byte_mask_t size_mask;
   byte_mask_t byte_mask;

   // processor data moved to its byte position
   line_t shifted_write;

   // byte mask widened to bits
   line_t bit_mask;

   // old line with the new bytes laid in
   line_t merged_line;

   // byte offset as a bit count
   logic [OFFSET_W+2:0] bit_shift;

   assign bit_shift = {offset, 3'b000};

   // raw indexed line, also the write-back payload
   assign line_out = mem[index];

   // read data aligned down to the requested byte
   // upper bytes fill with zeros
   assign data_read = line_out >> bit_shift;

   // size 1/2/4/8 gives that many low ones
   // size 0 is a full line
   always_comb
   begin
      if (size == '0)
      begin
         size_mask = '1;
      end
      else
      begin
         size_mask = (byte_mask_t'(1) << size) - byte_mask_t'(1);
      end
   end

   // shift out past bit 15 drops bytes beyond the line end
   assign byte_mask = size_mask << offset;

   // data follows the same shift
   assign shifted_write = data_write << bit_shift;

   // one byte enable covers eight data bits
   always_comb
   begin
      for (int b = 0; b < LINE_BYTES; b++)
      begin
         bit_mask[b*8 +: 8] = {8{byte_mask[b]}};
      end
   end

   assign merged_line = (line_out & ~bit_mask) | (shifted_write & bit_mask);

   // refill replaces the whole line
   // controller never raises both strobes together
   always_ff @(posedge clk)
   begin
      if (fill_write)
      begin
         mem[index] <= fill_line;
      end
      else if (cpu_write)
      begin
         mem[index] <= merged_line;
      end
   end

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

   // geometry of the cache and of the byte address
   localparam int ADDR_W     = 16;
   localparam int LINE_BYTES = 16;
   localparam int OFFSET_W   = 4;
   localparam int INDEX_W    = 5;
   localparam int NUM_LINES  = 32;
   // tag is whatever sits above index and offset
   localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
   localparam int LINE_W     = LINE_BYTES * 8;

   // address fields
   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // line payload and per byte enables
   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [LINE_BYTES-1:0] byte_mask_t;

   // byte count of an access, zero stands for a full line
   typedef logic [OFFSET_W-1:0] size_t;

   // request kind on the rw pin
   typedef enum logic
   {
      op_read  = 1'b0,
      op_write = 1'b1
   } req_op_e;

   // controller states
   typedef enum logic [2:0]
   {
      st_idle   = 3'd0,
      st_lookup = 3'd1,
      st_evict  = 3'd2,
      st_refill = 3'd3,
      st_done   = 3'd4
   } cache_state_e;

endpackage

//--- hw/cache_tag_store.sv
`timescale 1ns/10ps

module cache_tag_store
(
   input  logic            clk,
   input  logic            arst_n,
   input  cache_pkg::index_t index,
   input  cache_pkg::tag_t   tag,
   input  logic            fill,
   input  logic            set_dirty,
   output logic            hit,
   output logic            evict,
   output cache_pkg::tag_t   victim_tag
);
   import cache_pkg::*;

   // per line bookkeeping
   tag_t                 tag_mem [NUM_LINES];
   logic [NUM_LINES-1:0] valid;
   logic [NUM_LINES-1:0] dirty;

   // indexed entry
   logic line_valid;
   logic line_dirty;
   logic tag_match;

   assign victim_tag = tag_mem[index];
   assign line_valid = valid[index];
   assign line_dirty = dirty[index];
   assign tag_match  = (victim_tag == tag);

   // hit needs a live line with the same tag
   assign hit = line_valid && tag_match;

   // only a modified line of another tag must go back to memory
   // clean conflicts are simply overwritten by the refill
   assign evict = line_valid && !tag_match && line_dirty;

   // valid bits, the only state that must be known after reset
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid <= '0;
      end
      else if (fill)
      begin
         valid[index] <= 1'b1;
      end
   end

   // tag and dirty bits
   // dirty is never looked at while the line is invalid
   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         // fresh line from memory starts clean
         tag_mem[index] <= tag;
         dirty[index]   <= 1'b0;
      end
      else if (set_dirty)
      begin
         dirty[index] <= 1'b1;
      end
   end

endmodule

//--- hw/cache_top.sv
`timescale 1ns/10ps

module cache_top
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               enable,
   input  cache_pkg::req_op_e rw,
   input  cache_pkg::addr_t   addr,
   input  cache_pkg::size_t   size,
   input  cache_pkg::line_t   data_write,
   output cache_pkg::line_t   data_read,
   output logic               ready,
   output logic               bus_en,
   output logic               bus_wr,
   output cache_pkg::addr_t   bus_addr,
   output cache_pkg::line_t   bus_write,
   input  logic               bus_r,
   input  cache_pkg::line_t   bus_read
);
   import cache_pkg::*;

   // address split
   tag_t    tag;
   index_t  index;
   offset_t offset;

   // tag store results
   logic hit;
   logic evict;
   tag_t victim_tag;

   // controller strobes
   logic use_victim_tag;
   logic fill;
   logic set_dirty;
   logic cpu_write;
   logic fill_write;

   // tag of the line on the bus
   tag_t bus_tag;

   assign tag    = addr[ADDR_W-1 -: TAG_W];
   assign index  = addr[OFFSET_W +: INDEX_W];
   assign offset = addr[OFFSET_W-1:0];

   // victim tag during write-back, request tag for refill
   assign bus_tag = use_victim_tag ? victim_tag : tag;

   // always line aligned
   assign bus_addr = {bus_tag, index, {OFFSET_W{1'b0}}};

   cache_ctrl u_ctrl
   (
      .clk            (clk),
      .arst_n         (arst_n),
      .enable         (enable),
      .rw             (rw),
      .hit            (hit),
      .evict          (evict),
      .bus_r          (bus_r),
      .ready          (ready),
      .bus_en         (bus_en),
      .bus_wr         (bus_wr),
      .use_victim_tag (use_victim_tag),
      .fill           (fill),
      .set_dirty      (set_dirty),
      .cpu_write      (cpu_write),
      .fill_write     (fill_write)
   );

   cache_tag_store u_tags
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .index      (index),
      .tag        (tag),
      .fill       (fill),
      .set_dirty  (set_dirty),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (victim_tag)
   );

   // raw line feeds the write-back bus directly
   cache_data_array u_data
   (
      .clk        (clk),
      .index      (index),
      .offset     (offset),
      .size       (size),
      .data_write (data_write),
      .fill_line  (bus_read),
      .cpu_write  (cpu_write),
      .fill_write (fill_write),
      .line_out   (bus_write),
      .data_read  (data_read)
   );

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/10ps

module cache_tb;
   import cache_pkg::*;

   logic    clk;
   logic    arst_n;
   logic    enable;
   req_op_e rw;
   addr_t   addr;
   size_t   size;
   line_t   data_write;
   line_t   data_read;
   logic    ready;
   logic    bus_en;
   logic    bus_wr;
   addr_t   bus_addr;
   line_t   bus_write;
   logic    bus_r;
   line_t   bus_read;

   // reference state: processor view of memory plus per index tag info
   logic [7:0] shadow [65536];
   line_t      bus_mem [4096];
   tag_t       ref_tag [NUM_LINES];
   logic       ref_valid [NUM_LINES];
   logic       ref_dirty [NUM_LINES];

   // bus transfers predicted but not yet seen
   logic  exp_wr [$];
   addr_t exp_addr [$];
   line_t exp_data [$];

   logic [31:0] lfsr_state = 32'hf5b8_7d6e;
   string       cur_test;
   int          err_count;
   int          check_count;
   int          test_count;
   int          failed_tests;
   int          test_err_start;

   tb_clk_gen u_clk_gen
   (
      .clk    (clk),
      .arst_n (arst_n)
   );

   cache_top u_dut
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .rw         (rw),
      .addr       (addr),
      .size       (size),
      .data_write (data_write),
      .data_read  (data_read),
      .ready      (ready),
      .bus_en     (bus_en),
      .bus_wr     (bus_wr),
      .bus_addr   (bus_addr),
      .bus_write  (bus_write),
      .bus_r      (bus_r),
      .bus_read   (bus_read)
   );

   // galois lfsr, one step per bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        lsb;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lsb = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb)
         begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
         end
         r = {r[30:0], lsb};
      end
      return r;
   endfunction

   function automatic line_t random_line();
      line_t r;
      for (int w = 0; w < 4; w++)
      begin
         r[w*32 +: 32] = take_bits(32);
      end
      return r;
   endfunction

   // memory contents before any write, mixes every address bit
   function automatic logic [7:0] fill_byte(input int a);
      return 8'(a) ^ (8'(a >> 8) * 8'd7) ^ 8'h3c;
   endfunction

   function automatic line_t shadow_line(input addr_t a);
      line_t r;
      int    base;
      base = int'({a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
      for (int k = 0; k < LINE_BYTES; k++)
      begin
         r[k*8 +: 8] = shadow[base + k];
      end
      return r;
   endfunction

   // expected read data: bytes from offset up, zeros past the line end
   function automatic line_t expected_read(input addr_t a);
      line_t r;
      int    base;
      int    off;
      base = int'({a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
      off  = int'(a[OFFSET_W-1:0]);
      r    = '0;
      for (int k = 0; k < LINE_BYTES; k++)
      begin
         if (off + k < LINE_BYTES)
         begin
            r[k*8 +: 8] = shadow[base + off + k];
         end
      end
      return r;
   endfunction

   // size bytes land at the address, anything past the line end is lost
   task automatic merge_write(input addr_t a, input size_t sz, input line_t d);
      int base;
      int off;
      int n;
      base = int'({a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
      off  = int'(a[OFFSET_W-1:0]);
      n    = (sz == '0) ? LINE_BYTES : int'(sz);
      for (int k = 0; k < n; k++)
      begin
         if (off + k < LINE_BYTES)
         begin
            shadow[base + off + k] = d[k*8 +: 8];
         end
      end
   endtask

   // tag bookkeeping, queues the write-back and refill a request must cause
   task automatic predict_bus(input req_op_e op, input addr_t a, output logic hit);
      tag_t   t;
      index_t i;
      addr_t  victim;
      t   = a[ADDR_W-1 -: TAG_W];
      i   = a[OFFSET_W +: INDEX_W];
      hit = ref_valid[i] && (ref_tag[i] == t);
      if (!hit)
      begin
         if (ref_valid[i] && ref_dirty[i])
         begin
            victim = {ref_tag[i], i, {OFFSET_W{1'b0}}};
            exp_wr.push_back(1'b1);
            exp_addr.push_back(victim);
            exp_data.push_back(shadow_line(victim));
         end
         exp_wr.push_back(1'b0);
         exp_addr.push_back({t, i, {OFFSET_W{1'b0}}});
         exp_data.push_back('0);
         ref_tag[i]   = t;
         ref_valid[i] = 1'b1;
         ref_dirty[i] = 1'b0;
      end
      if (op == op_write)
      begin
         ref_dirty[i] = 1'b1;
      end
   endtask

   task automatic check_line(input string what, input line_t exp, input line_t act);
      check_count++;
      if (act !== exp)
      begin
         err_count++;
         $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_addr(input string what, input addr_t exp, input addr_t act);
      check_count++;
      if (act !== exp)
      begin
         err_count++;
         $display("FAIL %s %s: expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      check_count++;
      if (act !== exp)
      begin
         err_count++;
         $display("FAIL %s %s: expected %b actual %b", cur_test, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test       = name;
      test_err_start = err_count;
   endtask

   task automatic end_test();
      test_count++;
      if (err_count == test_err_start)
      begin
         $display("test %s: ok", cur_test);
      end
      else
      begin
         failed_tests++;
         $display("test %s: %0d errors", cur_test, err_count - test_err_start);
      end
   endtask

   // one processor request, start to the cycle after ready
   task automatic run_request(input req_op_e op, input addr_t a, input size_t sz,
                              input line_t d);
      logic  hit;
      line_t exp_read;
      int    cycles;
      predict_bus(op, a, hit);
      exp_read = expected_read(a);
      if (op == op_write)
      begin
         merge_write(a, sz, d);
      end
      @(posedge clk);
      #1;
      enable     = 1'b1;
      rw         = op;
      addr       = a;
      size       = sz;
      data_write = d;
      cycles     = 0;
      do
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      while (ready !== 1'b1);
      if (op == op_read)
      begin
         check_line("read data", exp_read, data_read);
      end
      if (hit)
      begin
         check_count++;
         if (cycles != 2)
         begin
            err_count++;
            $display("FAIL %s hit latency at %h: expected 2 actual %0d",
                     cur_test, a, cycles);
         end
      end
      // hold request through the ready cycle so the write lands
      @(posedge clk);
      #1;
      enable = 1'b0;
      check_flag("ready one cycle", 1'b0, ready);
      if (exp_addr.size() != 0)
      begin
         err_count++;
         $display("ERROR %s: request at %h ended with %0d bus transfers missing",
                  cur_test, a, exp_addr.size());
         exp_wr.delete();
         exp_addr.delete();
         exp_data.delete();
      end
   endtask

   // bus memory, answers each transfer after 1 to 4 cycles
   initial
   begin : bus_memory
      logic  busy;
      logic  cur_wr;
      addr_t cur_addr;
      line_t cur_data;
      logic  ew;
      line_t ed;
      int    wait_left;
      bus_r     = 1'b0;
      bus_read  = '0;
      busy      = 1'b0;
      wait_left = 0;
      forever
      begin
         @(posedge clk);
         #1;
         if (bus_r)
         begin
            // transfer taken at this edge, bus must be released
            bus_r    = 1'b0;
            bus_read = '0;
            busy     = 1'b0;
            check_flag("bus_en gap after transfer", 1'b0, bus_en);
         end
         else
         begin
            if (!busy && bus_en)
            begin
               busy      = 1'b1;
               cur_wr    = bus_wr;
               cur_addr  = bus_addr;
               cur_data  = bus_write;
               wait_left = 1 + int'(take_bits(2));
               if (exp_addr.size() == 0)
               begin
                  err_count++;
                  $display("ERROR %s: bus transfer to %h was not expected",
                           cur_test, bus_addr);
               end
               else
               begin
                  ew = exp_wr.pop_front();
                  ed = exp_data.pop_front();
                  check_flag("bus_wr", ew, bus_wr);
                  check_addr("bus_addr", exp_addr.pop_front(), bus_addr);
                  if (ew)
                  begin
                     check_line("write-back data", ed, bus_write);
                  end
               end
            end
            if (busy)
            begin
               check_flag("bus_en held", 1'b1, bus_en);
               check_addr("bus_addr held", cur_addr, bus_addr);
               wait_left--;
               if (wait_left == 0)
               begin
                  bus_r = 1'b1;
                  if (cur_wr)
                  begin
                     bus_mem[cur_addr[ADDR_W-1:OFFSET_W]] = cur_data;
                  end
                  else
                  begin
                     bus_read = bus_mem[cur_addr[ADDR_W-1:OFFSET_W]];
                  end
               end
            end
         end
      end
   end

   // watchdog sized for every request at 12 cycles
   initial
   begin : watchdog
      int cycle_count;
      int cycle_limit;
      cycle_count = 0;
      cycle_limit = (2 + 50 + 5 + 300) * 12 + 100;
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("ERROR: run stopped after %0d cycles, requests did not complete", cycle_count);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin : stimulus
      size_t   size_table [5];
      offset_t offset_table [5];
      tag_t    rt;
      index_t  ri;
      offset_t ro;
      req_op_e rop;
      size_t   rsz;
      enable       = 1'b0;
      rw           = op_read;
      addr         = '0;
      size         = '0;
      data_write   = '0;
      err_count    = 0;
      check_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      size_table   = '{4'd1, 4'd2, 4'd4, 4'd8, 4'd0};
      offset_table = '{4'd0, 4'd3, 4'd8, 4'd13, 4'd15};
      for (int a = 0; a < 65536; a++)
      begin
         shadow[a] = fill_byte(a);
      end
      for (int l = 0; l < 4096; l++)
      begin
         for (int k = 0; k < LINE_BYTES; k++)
         begin
            bus_mem[l][k*8 +: 8] = fill_byte(l * LINE_BYTES + k);
         end
      end
      for (int i = 0; i < NUM_LINES; i++)
      begin
         ref_valid[i] = 1'b0;
         ref_dirty[i] = 1'b0;
         ref_tag[i]   = '0;
      end

      wait (arst_n === 1'b1);
      @(posedge clk);
      #1;
      begin_test("reset");
      check_flag("ready", 1'b0, ready);
      check_flag("bus_en", 1'b0, bus_en);
      check_flag("bus_wr", 1'b0, bus_wr);
      end_test();

      begin_test("cold_read");
      run_request(op_read, 16'h0123, 4'd4, '0);
      end_test();

      begin_test("hit_read");
      run_request(op_read, 16'h0128, 4'd8, '0);
      end_test();

      // every size at offsets up to the last byte, full line read back each time
      begin_test("write_sizes");
      for (int s = 0; s < 5; s++)
      begin
         for (int o = 0; o < 5; o++)
         begin
            run_request(op_write, 16'h0340 | addr_t'(offset_table[o]), size_table[s],
                        random_line());
            run_request(op_read, 16'h0340, 4'd0, '0);
         end
      end
      end_test();

      // same index, other tag: dirty victim, then clean ones
      begin_test("conflict");
      run_request(op_read, 16'h2345, 4'd2, '0);
      run_request(op_read, 16'h0340, 4'd0, '0);
      run_request(op_write, 16'h2348, 4'd4, random_line());
      run_request(op_read, 16'h0340, 4'd0, '0);
      run_request(op_read, 16'h2340, 4'd0, '0);
      end_test();

      // few tags over few indexes keeps evictions frequent
      begin_test("random");
      for (int n = 0; n < 300; n++)
      begin
         rt  = tag_t'(take_bits(2));
         ri  = index_t'(take_bits(3));
         ro  = offset_t'(take_bits(4));
         rop = req_op_e'(take_bits(1));
         rsz = size_table[take_bits(3) % 5];
         run_request(rop, {rt, ri, ro}, rsz, random_line());
      end
      end_test();

      $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               test_count, failed_tests, check_count, err_count);
      if (err_count == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen
(
   output logic clk,
   output logic arst_n
);

   // 100 ns period
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   // reset held for two rising edges, released off the edge
   initial
   begin
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #10 arst_n = 1'b1;
   end

endmodule
